// ==== src/pulse_pkg.sv ====
`default_nettype none

package pulse_pkg;

  // PC link
  localparam int XB_SIZE     = 32;
  localparam int MSG_WORDS   = 3;
  localparam int PC_MSG_SIZE = MSG_WORDS * XB_SIZE;

  // ZMW grid
  localparam int N_ZMW          = 16;
  localparam int ZMW_ADDR_SIZE  = 4;
  localparam int PULSES_PER_ZMW = 3;

  localparam int FRAME_SIZE = 24;  // frame numbers
  localparam int CLOCK_SIZE = 24;  // clocks per frame
  localparam int DT_SIZE    = 16;  // pulse duration in frames

  // header fields, common to all messages
  localparam int MSG_TYPE_BIT = 0;  // 0 control, 1 pulse
  localparam int START_BIT    = 6;  // control only: 1 START, 0 STOP

  // START message
  localparam int N_FRAME_BIT         = 8;
  localparam int CLOCK_PER_FRAME_BIT = 32;

  // pulse message
  localparam int PULSE_ZMW_BIT       = 8;
  localparam int PULSE_T1_BIT        = 32;
  localparam int PULSE_DT_BIT        = 56;
  localparam int PULSE_DYE_BIT       = 72;
  localparam int PULSE_INTENSITY_BIT = 74;

  typedef struct packed {
    logic [FRAME_SIZE-1:0] end_frame;  // lit while frame_num < end_frame
    logic [1:0]            dye;
    logic [1:0]            intensity;
  } pulse_t;

  typedef pulse_t [PULSES_PER_ZMW-1:0] zmw_rec_t;

  typedef struct packed {
    logic [ZMW_ADDR_SIZE-1:0] zmw;
    pulse_t                   pulse;
  } pulse_msg_t;

  typedef enum logic [1:0] {STOPPED, CLEAR, FRAME, WAIT} pacer_state_t;

endpackage

`default_nettype wire

// ==== src/sweep_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// one sweep command per cycle, pacer to banks and updater
interface sweep_if;
  import pulse_pkg::*;

  logic                     sweep_valid;  // one cycle per zmw
  logic [ZMW_ADDR_SIZE-1:0] sweep_zmw;    // also the bank read address
  logic                     src_bank;     // bank read during this sweep
  logic                     clear;        // zero-fill sweep, nothing emitted

  modport master (
    output sweep_valid, sweep_zmw, src_bank, clear
  );

  modport slave (
    input sweep_valid, sweep_zmw, src_bank, clear
  );

endinterface

`default_nettype wire

// ==== src/pulse_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module pulse_fifo #(
  parameter int DEPTH = 4
) (
  input  wire                       CLK,
  input  wire                       RESET,
  input  wire                       push,
  input  wire pulse_pkg::pulse_msg_t push_data,
  input  wire                       pop,
  output pulse_pkg::pulse_msg_t     head,
  output logic                      empty,
  output logic                      full
);
  import pulse_pkg::*;

  pulse_msg_t                   mem [DEPTH];
  logic [$clog2(DEPTH)-1:0]     rd_ptr, wr_ptr;
  logic [$clog2(DEPTH+1)-1:0]   count;
  logic                         do_push, do_pop;

  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  assign head  = mem[rd_ptr];  // fall-through, head valid while !empty
  assign empty = count == '0;
  assign full  = count == ($clog2(DEPTH+1))'(DEPTH);

  always_ff @(posedge CLK) begin
    if (RESET) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push)
        wr_ptr <= (wr_ptr == ($clog2(DEPTH))'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= (rd_ptr == ($clog2(DEPTH))'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      if (do_push && !do_pop)
        count <= count + 1'b1;
      else if (do_pop && !do_push)
        count <= count - 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (do_push) mem[wr_ptr] <= push_data;
  end

endmodule

`default_nettype wire

// ==== src/msg_assembler.sv ====
`timescale 1ns/1ps
`default_nettype none

module msg_assembler (
  input  wire                                 CLK,
  input  wire                                 RESET,
  input  wire                                 pc_msg_valid,
  input  wire [pulse_pkg::XB_SIZE-1:0]        pc_msg,
  input  wire                                 fifo_full,
  output logic                                pc_msg_ack,
  output logic                                start_cmd,
  output logic                                stop_cmd,
  output logic [pulse_pkg::FRAME_SIZE-1:0]    n_frame,
  output logic [pulse_pkg::CLOCK_SIZE-1:0]    clocks_per_frame,
  output logic                                push,
  output pulse_pkg::pulse_msg_t               push_data
);
  import pulse_pkg::*;

  typedef enum logic [1:0] {WORD0, WORD1, WORD2} word_t;

  word_t                                word_cnt;
  logic [(MSG_WORDS-1)*XB_SIZE-1:0]     cache;      // first two words
  logic [PC_MSG_SIZE-1:0]               next_msg, whole_msg;
  logic                                 msg_valid;  // whole_msg is fresh
  logic                                 accept, is_pulse;

  assign pc_msg_ack = pc_msg_valid && !fifo_full;
  assign accept     = pc_msg_ack;
  assign next_msg   = {pc_msg, cache};  // last word on top

  always_ff @(posedge CLK) begin
    if (RESET) begin
      word_cnt  <= WORD0;
      msg_valid <= 1'b0;
    end else begin
      msg_valid <= accept && (word_cnt == WORD2);
      if (accept)
        word_cnt <= (word_cnt == WORD2) ? WORD0 : word_t'(word_cnt + 1'b1);
    end
  end

  always_ff @(posedge CLK) begin
    if (accept) begin
      case (word_cnt)
        WORD0: cache[0 +: XB_SIZE]       <= pc_msg;
        WORD1: cache[XB_SIZE +: XB_SIZE] <= pc_msg;
        default: begin
          whole_msg <= next_msg;
          // run parameters held until the next START
          if (!next_msg[MSG_TYPE_BIT] && next_msg[START_BIT]) begin
            n_frame          <= next_msg[N_FRAME_BIT +: FRAME_SIZE];
            clocks_per_frame <= next_msg[CLOCK_PER_FRAME_BIT +: CLOCK_SIZE];
          end
        end
      endcase
    end
  end

  // decode
  assign is_pulse  = whole_msg[MSG_TYPE_BIT];
  assign start_cmd = msg_valid && !is_pulse && whole_msg[START_BIT];
  assign stop_cmd  = msg_valid && !is_pulse && !whole_msg[START_BIT];
  assign push      = msg_valid && is_pulse;

  assign push_data.zmw             = whole_msg[PULSE_ZMW_BIT +: ZMW_ADDR_SIZE];
  assign push_data.pulse.end_frame = whole_msg[PULSE_T1_BIT +: FRAME_SIZE]
                                   + FRAME_SIZE'(whole_msg[PULSE_DT_BIT +: DT_SIZE]);
  assign push_data.pulse.dye       = whole_msg[PULSE_DYE_BIT +: 2];
  assign push_data.pulse.intensity = whole_msg[PULSE_INTENSITY_BIT +: 2];

endmodule

`default_nettype wire

// ==== src/frame_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_timer (
  input  wire                              CLK,
  input  wire                              RESET,
  input  wire                              load,
  input  wire                              stop,
  input  wire [pulse_pkg::CLOCK_SIZE-1:0]  clocks_per_frame,
  output logic                             frame_start,
  output logic [pulse_pkg::FRAME_SIZE-1:0] frame_num
);
  import pulse_pkg::*;

  logic [CLOCK_SIZE-1:0] period;
  logic [CLOCK_SIZE-1:0] clk_cnt;  // position within the frame
  logic                  running;

  assign frame_start = running && (clk_cnt == '0);

  always_ff @(posedge CLK) begin
    if (load) period <= clocks_per_frame;
  end

  always_ff @(posedge CLK) begin
    if (RESET) begin
      running   <= 1'b0;
      clk_cnt   <= '0;
      frame_num <= '0;
    end else if (load) begin
      running   <= 1'b1;  // first frame_start next cycle
      clk_cnt   <= '0;
      frame_num <= '0;
    end else if (stop) begin
      running <= 1'b0;
    end else if (running) begin
      clk_cnt <= (clk_cnt == period - 1'b1) ? '0 : clk_cnt + 1'b1;
      if (frame_start)
        frame_num <= frame_num + 1'b1;  // first frame is 1
    end
  end

endmodule

`default_nettype wire

// ==== src/pacer_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module pacer_fsm (
  input  wire                              CLK,
  input  wire                              RESET,
  input  wire                              start_cmd,
  input  wire                              stop_cmd,
  input  wire [pulse_pkg::FRAME_SIZE-1:0]  n_frame,
  input  wire                              frame_start,
  input  wire [pulse_pkg::FRAME_SIZE-1:0]  frame_num,
  output logic                             timer_load,
  output logic                             timer_stop,
  output pulse_pkg::pacer_state_t          state,
  sweep_if.master                          sweep
);
  import pulse_pkg::*;

  logic [ZMW_ADDR_SIZE-1:0] addr;        // sweep address
  logic                     src_bank;
  logic                     stop_pend;   // STOP seen, act at end of sweep
  logic [FRAME_SIZE-1:0]    last_frame;  // n_frame of this run
  logic                     last_zmw, run_done, to_stopped;

  assign sweep.sweep_valid = (state == CLEAR) || (state == FRAME);
  assign sweep.sweep_zmw   = addr;
  assign sweep.src_bank    = src_bank;
  assign sweep.clear       = state == CLEAR;

  assign last_zmw = addr == ZMW_ADDR_SIZE'(N_ZMW - 1);
  assign run_done = stop_pend || stop_cmd;

  always_comb begin
    to_stopped = 1'b0;
    case (state)
      CLEAR:   to_stopped = last_zmw && (run_done || last_frame == '0);
      FRAME:   to_stopped = last_zmw && (run_done || frame_num == last_frame);
      WAIT:    to_stopped = stop_cmd;  // no sweep in progress
      default: to_stopped = 1'b0;
    endcase
  end

  // timer starts as the clear sweep ends, first frame_start lands in WAIT
  assign timer_load = (state == CLEAR) && last_zmw && !to_stopped;
  assign timer_stop = to_stopped;

  always_ff @(posedge CLK) begin
    if (state == STOPPED && start_cmd) last_frame <= n_frame;
  end

  always_ff @(posedge CLK) begin
    if (RESET) begin
      state     <= STOPPED;
      addr      <= '0;
      src_bank  <= 1'b0;
      stop_pend <= 1'b0;
    end else begin
      if (stop_cmd && state != STOPPED) stop_pend <= 1'b1;
      case (state)
        STOPPED:
          if (start_cmd) begin
            state     <= CLEAR;
            addr      <= '0;
            src_bank  <= 1'b1;  // clear writes bank 0, first frame reads it
            stop_pend <= 1'b0;
          end
        CLEAR, FRAME: begin
          addr <= addr + 1'b1;
          if (last_zmw) state <= to_stopped ? STOPPED : WAIT;
        end
        WAIT:
          if (to_stopped) begin
            state <= STOPPED;
          end else if (frame_start) begin
            state    <= FRAME;
            src_bank <= ~src_bank;  // ping-pong
            addr     <= '0;
          end
        default: state <= STOPPED;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/zmw_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module zmw_bank (
  input  wire                                 CLK,
  input  wire [pulse_pkg::ZMW_ADDR_SIZE-1:0]  rd_addr,
  input  wire                                 wr_en,
  input  wire [pulse_pkg::ZMW_ADDR_SIZE-1:0]  wr_addr,
  input  wire pulse_pkg::zmw_rec_t            wr_data,
  output pulse_pkg::zmw_rec_t                 rd_data
);
  import pulse_pkg::*;

  zmw_rec_t mem [N_ZMW];  // one record per zmw

  always_ff @(posedge CLK) begin
    rd_data <= mem[rd_addr];  // one cycle read latency
    if (wr_en) mem[wr_addr] <= wr_data;
  end

endmodule

`default_nettype wire

// ==== src/slot_updater.sv ====
`timescale 1ns/1ps
`default_nettype none

module slot_updater (
  input  wire                                     CLK,
  input  wire                                     RESET,
  sweep_if.slave                                  sweep,
  input  wire pulse_pkg::zmw_rec_t                rd_data0,
  input  wire pulse_pkg::zmw_rec_t                rd_data1,
  input  wire [pulse_pkg::FRAME_SIZE-1:0]         frame_num,
  input  wire pulse_pkg::pulse_msg_t              head,
  input  wire                                     empty,
  output logic                                    pop,
  output logic                                    wr_en0,
  output logic                                    wr_en1,
  output logic [pulse_pkg::ZMW_ADDR_SIZE-1:0]     wr_addr,
  output pulse_pkg::zmw_rec_t                     wr_data,
  output logic                                    emit_valid,
  output logic [pulse_pkg::ZMW_ADDR_SIZE-1:0]     emit_zmw,
  output logic [pulse_pkg::PULSES_PER_ZMW-1:0]    emit_active
);
  import pulse_pkg::*;

  // stage 1, lined up with the bank read data
  logic                      s1_valid, s1_src, s1_clear;
  logic [ZMW_ADDR_SIZE-1:0]  s1_zmw;
  zmw_rec_t                  rec, new_rec;
  logic [PULSES_PER_ZMW-1:0] expired, active;
  logic                      hit, taken;

  always_ff @(posedge CLK) begin
    if (RESET) s1_valid <= 1'b0;
    else       s1_valid <= sweep.sweep_valid;
  end

  always_ff @(posedge CLK) begin
    s1_zmw   <= sweep.sweep_zmw;
    s1_src   <= sweep.src_bank;
    s1_clear <= sweep.clear;
  end

  always_comb begin
    rec = s1_clear ? '0 : (s1_src ? rd_data1 : rd_data0);
    for (int i = 0; i < PULSES_PER_ZMW; i++)
      expired[i] = rec[i].end_frame <= frame_num;
  end

  // queued pulse only goes in when it is for this zmw and there is room
  assign hit = s1_valid && !s1_clear && !empty && (head.zmw == s1_zmw) && |expired;
  assign pop = hit;

  always_comb begin
    new_rec = rec;
    taken   = 1'b0;
    for (int i = 0; i < PULSES_PER_ZMW; i++) begin
      if (hit && expired[i] && !taken) begin
        new_rec[i] = head.pulse;  // lowest expired slot
        taken      = 1'b1;
      end
    end
    for (int i = 0; i < PULSES_PER_ZMW; i++)
      active[i] = new_rec[i].end_frame > frame_num;
  end

  // stage 2, write the other bank and emit together
  always_ff @(posedge CLK) begin
    if (RESET) begin
      wr_en0     <= 1'b0;
      wr_en1     <= 1'b0;
      emit_valid <= 1'b0;
    end else begin
      wr_en0     <= s1_valid && s1_src;
      wr_en1     <= s1_valid && !s1_src;
      emit_valid <= s1_valid && !s1_clear;
    end
  end

  always_ff @(posedge CLK) begin
    wr_addr     <= s1_zmw;
    wr_data     <= new_rec;
    emit_zmw    <= s1_zmw;
    emit_active <= active;
  end

endmodule

`default_nettype wire

// ==== src/pulse_sim_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module pulse_sim_top (
  input  wire                                  CLK,
  input  wire                                  RESET,
  input  wire                                  pc_msg_valid,
  input  wire [pulse_pkg::XB_SIZE-1:0]         pc_msg,
  output logic                                 pc_msg_ack,
  output logic                                 app_running,
  output logic                                 emit_valid,
  output logic [pulse_pkg::ZMW_ADDR_SIZE-1:0]  emit_zmw,
  output logic [pulse_pkg::PULSES_PER_ZMW-1:0] emit_active
);
  import pulse_pkg::*;

  logic                     start_cmd, stop_cmd;
  logic [FRAME_SIZE-1:0]    n_frame, frame_num;
  logic [CLOCK_SIZE-1:0]    clocks_per_frame;
  logic                     push, pop, empty, full;
  pulse_msg_t               push_data, head;
  logic                     frame_start, timer_load, timer_stop;
  pacer_state_t             state;
  zmw_rec_t                 rd_data0, rd_data1, wr_data;
  logic                     wr_en0, wr_en1;
  logic [ZMW_ADDR_SIZE-1:0] wr_addr;

  sweep_if sweep_i ();

  assign app_running = (state == FRAME) || (state == WAIT);

  msg_assembler msg_assembler_i (
    .CLK, .RESET, .pc_msg_valid, .pc_msg, .fifo_full(full), .pc_msg_ack,
    .start_cmd, .stop_cmd, .n_frame, .clocks_per_frame, .push, .push_data
  );

  pulse_fifo #(.DEPTH(4)) pulse_fifo_i (
    .CLK, .RESET, .push, .push_data, .pop, .head, .empty, .full
  );

  frame_timer frame_timer_i (
    .CLK, .RESET, .load(timer_load), .stop(timer_stop), .clocks_per_frame,
    .frame_start, .frame_num
  );

  pacer_fsm pacer_fsm_i (
    .CLK, .RESET, .start_cmd, .stop_cmd, .n_frame, .frame_start, .frame_num,
    .timer_load, .timer_stop, .state, .sweep(sweep_i.master)
  );

  zmw_bank bank0_i (
    .CLK, .rd_addr(sweep_i.sweep_zmw), .wr_en(wr_en0), .wr_addr, .wr_data,
    .rd_data(rd_data0)
  );

  zmw_bank bank1_i (
    .CLK, .rd_addr(sweep_i.sweep_zmw), .wr_en(wr_en1), .wr_addr, .wr_data,
    .rd_data(rd_data1)
  );

  slot_updater slot_updater_i (
    .CLK, .RESET, .sweep(sweep_i.slave), .rd_data0, .rd_data1, .frame_num,
    .head, .empty, .pop, .wr_en0, .wr_en1, .wr_addr, .wr_data,
    .emit_valid, .emit_zmw, .emit_active
  );

endmodule

`default_nettype wire

// ==== tests/tb_pulse_sim.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_pulse_sim;

  // message layout and test sizes, as seen from the PC side
  localparam int ZMWS      = 16;
  localparam int SLOTS     = 3;
  localparam int TYPE_BIT  = 0;
  localparam int START_BIT = 6;
  localparam int NF_LSB    = 8;
  localparam int CPF_LSB   = 32;
  localparam int ZMW_LSB   = 8;
  localparam int T1_LSB    = 32;
  localparam int DT_LSB    = 56;
  localparam int DYE_LSB   = 72;
  localparam int INT_LSB   = 74;
  localparam int FULL_ZMW  = 5;  // zmw used for the full-slot test
  // frames x clocks per frame over all runs, plus margin for messages and clears
  localparam int TIMEOUT   = 5*30 + 8*24 + 12*20 + 3*120 + 10*40 + 1500;

  logic        CLK = 1'b0;
  logic        RESET = 1'b1;
  logic        pc_msg_valid;
  logic [31:0] pc_msg;
  logic        pc_msg_ack, app_running, emit_valid;
  logic [3:0]  emit_zmw;
  logic [2:0]  emit_active;
  logic        fifo_full;

  int seed;
  int cycle = 0;
  int first_cycle = 0;   // cycle of the first emit of the last frame
  int run_cpf = 0;
  int stall_cnt = 0;     // cycles with a word offered but not taken
  int starts_sent = 0;
  int starts_seen = 0;
  logic ack_seen = 1'b0;
  logic [23:0] frame_cnt = '0;  // frames emitted in this run
  logic [3:0]  exp_zmw = '0;
  int err_main = 0, err_reset = 0, err_ack = 0, err_zmw = 0;
  int err_burst = 0, err_space = 0, err_active = 0;

  // reference model: slot end frames and the pulse queue
  logic [23:0] m_end [ZMWS][SLOTS];
  logic [3:0]  q_zmw [32];
  logic [23:0] q_end [32];
  logic [4:0]  q_rd = '0, q_wr = '0;
  logic [23:0] cur_frame;
  logic [23:0] nxt_end [SLOTS];
  logic        take, placed;
  logic [2:0]  exp_active;

  pulse_sim_top pulse_sim_top_i (
    .CLK, .RESET, .pc_msg_valid, .pc_msg, .pc_msg_ack, .app_running,
    .emit_valid, .emit_zmw, .emit_active
  );

  assign fifo_full = pulse_sim_top_i.full;

  always #2 CLK = ~CLK;

  // expected mask for the zmw on emit_zmw this cycle
  always_comb begin
    cur_frame = (emit_zmw == 4'd0) ? frame_cnt + 24'd1 : frame_cnt;
    take      = (q_rd != q_wr) && (q_zmw[q_rd] == emit_zmw);
    placed    = 1'b0;
    for (int i = 0; i < SLOTS; i++)
      nxt_end[i] = m_end[emit_zmw][i];
    for (int i = 0; i < SLOTS; i++) begin
      if (take && !placed && nxt_end[i] <= cur_frame) begin
        nxt_end[i] = q_end[q_rd];  // lowest expired slot
        placed     = 1'b1;
      end
    end
    for (int i = 0; i < SLOTS; i++)
      exp_active[i] = nxt_end[i] > cur_frame;
  end

  always @(posedge CLK) begin
    cycle    <= cycle + 1;
    ack_seen <= pc_msg_valid && pc_msg_ack;
    if (pc_msg_valid && !pc_msg_ack)
      stall_cnt <= stall_cnt + 1;
    if (starts_seen != starts_sent) begin
      starts_seen <= starts_sent;  // new run, all records start empty
      frame_cnt   <= '0;
      for (int z = 0; z < ZMWS; z++)
        for (int i = 0; i < SLOTS; i++)
          m_end[z][i] <= '0;
    end else if (emit_valid) begin
      if (emit_zmw == 4'd0) begin
        frame_cnt   <= frame_cnt + 24'd1;
        first_cycle <= cycle;
      end
      exp_zmw <= emit_zmw + 4'd1;
      for (int i = 0; i < SLOTS; i++)
        m_end[emit_zmw][i] <= nxt_end[i];
      if (placed)
        q_rd <= q_rd + 5'd1;
    end
  end

  always @(posedge CLK) begin
    if (cycle >= TIMEOUT) begin
      $display("timeout after %0d cycles, a run did not finish", cycle);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  idle_after_reset: assert property (@(posedge CLK) RESET |=> !app_running && !emit_valid)
    else begin
      $display("[ERROR] app_running %h emit_valid %h, expected 0 after reset",
               $sampled(app_running), $sampled(emit_valid));
      err_reset++;
    end

  ack_follows_valid: assert property (@(posedge CLK) disable iff (RESET)
      !fifo_full |-> pc_msg_ack == pc_msg_valid)
    else begin
      $display("[ERROR] pc_msg_ack got %h, expected %h",
               $sampled(pc_msg_ack), $sampled(pc_msg_valid));
      err_ack++;
    end

  zmw_in_order: assert property (@(posedge CLK) disable iff (RESET)
      emit_valid |-> emit_zmw == exp_zmw)
    else begin
      $display("[ERROR] emit_zmw got %h, expected %h", $sampled(emit_zmw), $sampled(exp_zmw));
      err_zmw++;
    end

  sweep_unbroken: assert property (@(posedge CLK) disable iff (RESET)
      emit_valid && emit_zmw != 4'hf |=> emit_valid)
    else begin
      $display("emission stopped in the middle of a frame sweep");
      err_burst++;
    end

  frame_spacing: assert property (@(posedge CLK) disable iff (RESET)
      emit_valid && emit_zmw == 4'd0 && frame_cnt != 24'd0 |-> cycle - first_cycle == run_cpf)
    else begin
      $display("[ERROR] frame spacing got %h, expected %h",
               $sampled(cycle) - $sampled(first_cycle), $sampled(run_cpf));
      err_space++;
    end

  slots_match: assert property (@(posedge CLK) disable iff (RESET)
      emit_valid |-> emit_active == exp_active)
    else begin
      $display("[ERROR] emit_active zmw %h frame %h got %h, expected %h",
               $sampled(emit_zmw), $sampled(cur_frame), $sampled(emit_active),
               $sampled(exp_active));
      err_active++;
    end

  function automatic int total_errors();
    return err_main + err_reset + err_ack + err_zmw + err_burst + err_space + err_active;
  endfunction

  function automatic int rand_below(input int n);
    int r;
    r = $random(seed);
    return (r & 32'h7fff_ffff) % n;
  endfunction

  // three words, lowest first; called on a falling edge
  task automatic send_msg(input logic [95:0] m);
    for (int w = 0; w < 3; w++) begin
      pc_msg_valid = 1'b1;
      pc_msg       = m[w*32 +: 32];
      do @(negedge CLK); while (!ack_seen);
    end
    pc_msg_valid = 1'b0;
  endtask

  task automatic start_run(input logic [23:0] nf, input logic [23:0] cpf);
    logic [95:0] m;
    m = '0;
    m[START_BIT]      = 1'b1;
    m[NF_LSB +: 24]   = nf;
    m[CPF_LSB +: 24]  = cpf;
    run_cpf = int'(cpf);
    send_msg(m);
    starts_sent++;
  endtask

  task automatic queue_pulse(input logic [3:0] zmw, input logic [23:0] t1,
                             input logic [15:0] dt);
    logic [95:0] m;
    m = '0;
    m[TYPE_BIT]      = 1'b1;
    m[ZMW_LSB +: 4]  = zmw;
    m[T1_LSB +: 24]  = t1;
    m[DT_LSB +: 16]  = dt;
    m[DYE_LSB +: 2]  = 2'(rand_below(4));
    m[INT_LSB +: 2]  = 2'(rand_below(4));
    send_msg(m);
    q_zmw[q_wr] = zmw;
    q_end[q_wr] = t1 + 24'(dt);  // pulse lit while frame < t1+dt
    q_wr = q_wr + 5'd1;
  endtask

  // frame count of the run just started, not the one before
  task automatic wait_frames(input logic [23:0] n);
    while (starts_seen != starts_sent || frame_cnt < n) @(negedge CLK);
  endtask

  task automatic wait_run_end();
    while (!app_running) @(negedge CLK);
    while (app_running) @(negedge CLK);
    repeat (4) @(negedge CLK);  // last two zmws still in the pipeline
  endtask

  task automatic check_run(input logic [23:0] n);
    assert (frame_cnt == n)
      else begin
        $display("[ERROR] frame count got %h, expected %h", frame_cnt, n);
        err_main++;
      end
    assert (q_rd == q_wr)
      else begin
        $display("queued pulses were never placed into a slot");
        err_main++;
      end
  endtask

  task automatic report(input int n, input string name, input int mark);
    int errs;
    errs = total_errors() - mark;
    if (errs == 0)
      $display("test %0d %s: ok", n, name);
    else
      $display("test %0d %s: %0d errors", n, name, errs);
  endtask

  initial begin
    int mark;
    int stall_mark;
    logic [3:0] z;
    seed = 32'h24a9;
    pc_msg_valid = 1'b0;
    pc_msg = '0;
    repeat (10) @(negedge CLK);
    RESET = 1'b0;

    mark = total_errors();
    repeat (3) @(negedge CLK);
    assert (!app_running && !emit_valid)
      else begin
        $display("[ERROR] app_running %h emit_valid %h, expected 0", app_running, emit_valid);
        err_main++;
      end
    report(1, "reset state", mark);

    mark = total_errors();
    send_msg('0);  // STOP while stopped is ignored
    repeat (3) @(negedge CLK);
    report(2, "ack follows valid", mark);

    mark = total_errors();
    start_run(24'd5, 24'd30);
    wait_run_end();
    check_run(24'd5);
    report(3, "frame count and spacing", mark);

    mark = total_errors();
    z = 4'd0;
    for (int k = 0; k < 3; k++) begin  // a full FIFO would block the START
      queue_pulse(z, 24'(rand_below(4)), 16'(1 + rand_below(6)));
      z = z + 4'(1 + rand_below(3));  // increasing zmw order
    end
    start_run(24'd8, 24'd24);
    wait_run_end();
    check_run(24'd8);
    report(4, "slot placement", mark);

    mark = total_errors();
    queue_pulse(4'(FULL_ZMW), 24'd0, 16'd8);
    queue_pulse(4'(FULL_ZMW), 24'd0, 16'd9);
    queue_pulse(4'(FULL_ZMW), 24'd0, 16'd10);
    start_run(24'd12, 24'd20);
    wait_frames(24'd2);
    queue_pulse(4'(FULL_ZMW), 24'd4, 16'd8);  // waits until frame 8
    wait_run_end();
    check_run(24'd12);
    report(5, "full slots", mark);

    mark = total_errors();
    start_run(24'd3, 24'd120);
    wait_frames(24'd1);
    repeat (20) @(negedge CLK);  // frame 1 sweep is over, long wait follows
    stall_mark = stall_cnt;
    for (int k = 1; k <= 4; k++)
      queue_pulse(4'(k), 24'd2, 16'(1 + rand_below(3)));
    queue_pulse(4'd0, 24'd3, 16'd1);  // blocked until frame 2 pops
    assert (stall_cnt - stall_mark > 40)
      else begin
        $display("pc_msg_ack was not held low while the FIFO was full");
        err_main++;
      end
    wait_run_end();
    check_run(24'd3);
    start_run(24'd10, 24'd40);
    wait_frames(24'd2);
    send_msg('0);  // STOP during the frame 2 sweep
    wait_run_end();
    check_run(24'd2);
    report(6, "back-pressure and stop", mark);

    $display("6 tests run, %0d errors", total_errors());
    if (total_errors() == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
src/pulse_pkg.sv
src/sweep_if.sv
src/pulse_fifo.sv
src/msg_assembler.sv
src/frame_timer.sv
src/pacer_fsm.sv
src/zmw_bank.sv
src/slot_updater.sv
src/pulse_sim_top.sv
tests/tb_pulse_sim.sv

// ==== run.sh ====
#!/bin/sh
# compile with Verilator and run, pass only if the testbench reports it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_pulse_sim -f tb.f -o tb_pulse_sim &&
./obj_dir/tb_pulse_sim | tee /dev/stderr | grep -q "TESTBENCH PASSED" &&
echo "simulation ok" ||
{ echo "simulation did not pass"; exit 1; }
